// ==== vlog.f ====
+incdir+.
bus_pkg.sv
icache_pkg.sv
icache_array.sv
icache_ctrl.sv
data_port.sv
wb_arbiter.sv
main_mem.sv
fetch_subsys_top.sv
tb_fetch_subsys.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_fetch_subsys
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_fetch_subsys.sv ====
`include "fetch_macros.svh"

module tb_fetch_subsys;

   localparam int          PERIOD    = 40;
   localparam int          AW        = $clog2(`MEM_WORDS);
   localparam int          N_DATA    = 8;
   localparam int          N_PROG    = 8;
   localparam logic [31:0] DATA_BASE = 32'h800;
   localparam logic [31:0] PROG_BASE = 32'h100;  // Two lines, index 0 and 1.
   localparam logic [31:0] CONF_BASE = 32'h200;  // Index 0 with another tag.
   localparam logic [31:0] COLD_BASE = 32'h300;
   localparam logic [31:0] CONC_BASE = 32'h400;
   // Fetch and data operations issued by all tests together.
   localparam int          NUM_OPS   = 3 * N_DATA + 4 * N_PROG + 18;
   localparam int          WATCHDOG_CYCLES = (NUM_OPS + 16) * 64;

   logic                   clk;
   logic                   rst;
   logic                   stall;
   logic [31:0]            fetch_pc;
   icache_pkg::fetch_rsp_t fetch_rsp;
   bus_pkg::data_req_t     dreq;
   logic                   dp_done;
   logic [31:0]            dp_rdata;

   logic [31:0]            ref_mem [`MEM_WORDS];
   integer                 seed = 23171;

   fetch_subsys_top i_dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .stall_i     (stall),
      .fetch_pc_i  (fetch_pc),
      .fetch_rsp_o (fetch_rsp),
      .dreq_i      (dreq),
      .dp_done_o   (dp_done),
      .dp_rdata_o  (dp_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not complete within %0d clock cycles.", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1);
   end

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string msg);
      if (actual !== expected) begin
         $display("FAILED at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   // Outputs are sampled at the falling edge before new inputs go out.
   task automatic data_access(input bus_pkg::data_op_e op, input logic [31:0] addr,
                              input logic [31:0] wdata);
      @(negedge clk);
      dreq.valid = 1'b1;
      dreq.op    = op;
      dreq.addr  = addr;
      dreq.wdata = wdata;
      @(negedge clk);
      while (dp_done !== 1'b1) @(negedge clk);
      dreq.valid = 1'b0;
   endtask

   task automatic do_store(input logic [31:0] addr, input logic [31:0] data);
      ref_mem[addr[AW+1:2]] = data;
      data_access(bus_pkg::DOP_STORE, addr, data);
   endtask

   task automatic do_load(input logic [31:0] addr);
      data_access(bus_pkg::DOP_LOAD, addr, 32'd0);
      check(dp_rdata, ref_mem[addr[AW+1:2]], "load data");
   endtask

   task automatic store_block(input logic [31:0] base, input int words);
      for (int i = 0; i < words; i++) begin
         do_store(base + 32'(i * 4), $random(seed));
      end
   endtask

   task automatic wait_fetch(input logic [31:0] pc);
      @(negedge clk);
      while (fetch_rsp.valid !== 1'b1) @(negedge clk);
      check(fetch_rsp.pc, pc, "fetch response pc");
      check(fetch_rsp.instr, ref_mem[pc[AW+1:2]], "fetch response instruction");
   endtask

   task automatic fetch_at(input logic [31:0] pc);
      @(negedge clk);
      fetch_pc = pc;
      stall    = 1'b0;
      wait_fetch(pc);
      @(negedge clk);
      stall = 1'b1;  // Controller is back in idle here.
   endtask

   task automatic expect_quiet(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check(32'(fetch_rsp.valid), 32'd0, "unexpected fetch response");
         check(32'(dp_done), 32'd0, "unexpected data done");
      end
   endtask

   task automatic reset_idle();
      rst = 1'b0;
      repeat (5) @(negedge clk);
      rst = 1'b1;
      expect_quiet(8);
   endtask

   task automatic store_load();
      for (int i = 0; i < N_DATA; i++) begin
         do_store(DATA_BASE + 32'(i * 12), $random(seed));
      end
      for (int i = 0; i < N_DATA; i++) begin
         do_load(DATA_BASE + 32'(i * 12));
      end
   endtask

   task automatic miss_refill();
      store_block(PROG_BASE, N_PROG);
      store_block(CONF_BASE, 4);
      for (int i = 0; i < N_PROG; i++) begin
         fetch_at(PROG_BASE + 32'(i * 4));
      end
   endtask

   task automatic hit_and_evict();
      for (int i = 0; i < N_PROG; i++) begin
         fetch_at(PROG_BASE + 32'(i * 4));
      end
      fetch_at(CONF_BASE + 32'h8);
      fetch_at(PROG_BASE + 32'h8);
      fetch_at(PROG_BASE + 32'h4);
   endtask

   task automatic redirect_and_stall();
      store_block(COLD_BASE, 4);
      @(negedge clk);
      fetch_pc = COLD_BASE + 32'h8;
      stall    = 1'b0;
      expect_quiet(4);  // Refill of the cold line is under way.
      fetch_pc = PROG_BASE + 32'h14;
      wait_fetch(PROG_BASE + 32'h14);
      @(negedge clk);
      stall = 1'b1;
      // The abandoned line still lands in the cache.
      fetch_at(COLD_BASE + 32'h8);
      @(negedge clk);
      fetch_pc = PROG_BASE;
      stall    = 1'b0;
      expect_quiet(2);
      stall = 1'b1;
      expect_quiet(20);
      stall = 1'b0;
      wait_fetch(PROG_BASE);
      @(negedge clk);
      stall = 1'b1;
   endtask

   task automatic concurrent_traffic();
      store_block(CONC_BASE, N_PROG);
      fork
         begin
            fetch_at(CONC_BASE);
            fetch_at(CONC_BASE + 32'h4);
            fetch_at(CONC_BASE + 32'h18);
            fetch_at(CONC_BASE + 32'h1c);
         end
         begin
            for (int i = 0; i < N_DATA; i++) begin
               do_load(DATA_BASE + 32'(i * 12));
            end
         end
      join
   endtask

   initial begin
      rst      = 1'b0;
      stall    = 1'b1;
      fetch_pc = '0;
      dreq     = '0;
      reset_idle();
      store_load();
      miss_refill();
      hit_and_evict();
      redirect_and_stall();
      concurrent_traffic();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

// ==== fetch_subsys_top.sv ====
module fetch_subsys_top (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   stall_i,
   input  logic [31:0]            fetch_pc_i,
   output icache_pkg::fetch_rsp_t fetch_rsp_o,
   input  bus_pkg::data_req_t     dreq_i,
   output logic                   dp_done_o,
   output logic [31:0]            dp_rdata_o
);

   logic              hit;
   logic [31:0]       hit_word;
   logic              wr_en;
   logic [31:0]       wr_pc;
   icache_pkg::line_t wr_line;

   bus_pkg::wb_req_t  ic_req;
   bus_pkg::wb_rsp_t  ic_rsp;
   bus_pkg::wb_req_t  dp_req;
   bus_pkg::wb_rsp_t  dp_rsp;
   bus_pkg::wb_req_t  mem_req;
   bus_pkg::wb_rsp_t  mem_rsp;

   icache_array i_icache_array (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .lookup_pc_i (fetch_pc_i),
      .hit_o       (hit),
      .hit_word_o  (hit_word),
      .wr_en_i     (wr_en),
      .wr_pc_i     (wr_pc),
      .wr_line_i   (wr_line)
   );

   icache_ctrl i_icache_ctrl (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .stall_i     (stall_i),
      .fetch_pc_i  (fetch_pc_i),
      .fetch_rsp_o (fetch_rsp_o),
      .hit_i       (hit),
      .hit_word_i  (hit_word),
      .wr_en_o     (wr_en),
      .wr_pc_o     (wr_pc),
      .wr_line_o   (wr_line),
      .wb_req_o    (ic_req),
      .wb_rsp_i    (ic_rsp)
   );

   data_port i_data_port (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .dreq_i     (dreq_i),
      .dp_done_o  (dp_done_o),
      .dp_rdata_o (dp_rdata_o),
      .wb_req_o   (dp_req),
      .wb_rsp_i   (dp_rsp)
   );

   // Instruction side is master 0.
   wb_arbiter i_wb_arbiter (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .m0_req_i (ic_req),
      .m0_rsp_o (ic_rsp),
      .m1_req_i (dp_req),
      .m1_rsp_o (dp_rsp),
      .s_req_o  (mem_req),
      .s_rsp_i  (mem_rsp)
   );

   main_mem i_main_mem (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (mem_req),
      .wb_rsp_o (mem_rsp)
   );

endmodule

// ==== main_mem.sv ====
`include "fetch_macros.svh"

module main_mem (
   input  logic             clk_i,
   input  logic             rst_i,
   input  bus_pkg::wb_req_t wb_req_i,
   output bus_pkg::wb_rsp_t wb_rsp_o
);

   localparam int AW = $clog2(`MEM_WORDS);

   logic [31:0]   mem_q [`MEM_WORDS];
   logic          ack_q;
   logic [31:0]   rdata_q;
   logic [AW-1:0] word_adr;
   logic          req;

   assign word_adr = wb_req_i.adr[AW+1:2];
   assign req      = wb_req_i.cyc && wb_req_i.stb;

   // One wait state, then a single-cycle ack.
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req && !ack_q;
      end
   end

   always_ff @(posedge clk_i) begin
      if (req && !ack_q) begin
         rdata_q <= mem_q[word_adr];
      end
      if (req && ack_q && wb_req_i.we) begin
         mem_q[word_adr] <= wb_req_i.dat;  // Address and data still held during ack.
      end
   end

   always_comb begin
      wb_rsp_o.ack = ack_q;
      wb_rsp_o.dat = rdata_q;
   end

endmodule

// ==== wb_arbiter.sv ====
module wb_arbiter (
   input  logic             clk_i,
   input  logic             rst_i,
   input  bus_pkg::wb_req_t m0_req_i,
   output bus_pkg::wb_rsp_t m0_rsp_o,
   input  bus_pkg::wb_req_t m1_req_i,
   output bus_pkg::wb_rsp_t m1_rsp_o,
   output bus_pkg::wb_req_t s_req_o,
   input  bus_pkg::wb_rsp_t s_rsp_i
);

   logic busy_q;
   logic grant_q;  // 0 selects master 0.
   logic last_q;   // Winner of the previous grant.
   logic winner;
   logic granted_cyc;

   // On contention the master that lost last time goes first.
   always_comb begin
      if (m0_req_i.cyc && m1_req_i.cyc) begin
         winner = ~last_q;
      end else begin
         winner = m1_req_i.cyc;
      end
   end

   assign granted_cyc = grant_q ? m1_req_i.cyc : m0_req_i.cyc;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         busy_q  <= 1'b0;
         grant_q <= 1'b0;
         last_q  <= 1'b0;
      end else if (!busy_q) begin
         if (m0_req_i.cyc || m1_req_i.cyc) begin
            busy_q  <= 1'b1;
            grant_q <= winner;
            last_q  <= winner;
         end
      end else if (!granted_cyc) begin
         busy_q <= 1'b0;  // Bus idles one cycle before the next grant.
      end
   end

   always_comb begin
      s_req_o  = '0;
      m0_rsp_o = '0;
      m1_rsp_o = '0;
      if (busy_q) begin
         if (grant_q) begin
            s_req_o  = m1_req_i;
            m1_rsp_o = s_rsp_i;
         end else begin
            s_req_o  = m0_req_i;
            m0_rsp_o = s_rsp_i;
         end
      end
   end

endmodule

// ==== data_port.sv ====
module data_port (
   input  logic               clk_i,
   input  logic               rst_i,
   input  bus_pkg::data_req_t dreq_i,
   output logic               dp_done_o,
   output logic [31:0]        dp_rdata_o,
   output bus_pkg::wb_req_t   wb_req_o,
   input  bus_pkg::wb_rsp_t   wb_rsp_i
);

   typedef enum logic {
      DP_IDLE,
      DP_BUS
   } dp_state_e;

   dp_state_e   state_q;
   logic        done_q;
   logic [31:0] rdata_q;

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q <= DP_IDLE;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            DP_IDLE: begin
               // Still the old request while done is showing.
               if (dreq_i.valid && !done_q) state_q <= DP_BUS;
            end
            DP_BUS: begin
               if (wb_rsp_i.ack) begin
                  state_q <= DP_IDLE;
                  done_q  <= 1'b1;
               end
            end
            default: state_q <= DP_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == DP_BUS && wb_rsp_i.ack && dreq_i.op == bus_pkg::DOP_LOAD) begin
         rdata_q <= wb_rsp_i.dat;
      end
   end

   always_comb begin
      wb_req_o     = '0;
      wb_req_o.cyc = (state_q == DP_BUS);
      wb_req_o.stb = (state_q == DP_BUS);
      wb_req_o.we  = (dreq_i.op == bus_pkg::DOP_STORE);
      wb_req_o.adr = dreq_i.addr;
      wb_req_o.dat = dreq_i.wdata;
   end

   assign dp_done_o  = done_q;
   assign dp_rdata_o = rdata_q;

endmodule

// ==== icache_ctrl.sv ====
`include "fetch_macros.svh"

module icache_ctrl (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   stall_i,
   input  logic [31:0]            fetch_pc_i,
   output icache_pkg::fetch_rsp_t fetch_rsp_o,
   input  logic                   hit_i,
   input  logic [31:0]            hit_word_i,
   output logic                   wr_en_o,
   output logic [31:0]            wr_pc_o,
   output icache_pkg::line_t      wr_line_o,
   output bus_pkg::wb_req_t       wb_req_o,
   input  bus_pkg::wb_rsp_t       wb_rsp_i
);

   icache_pkg::ictrl_state_e state_q;
   icache_pkg::ictrl_state_e state_d;

   logic [`OFS_BITS-1:0] beat_q;
   logic                 last_beat;
   logic                 beat_ack;
   logic [31:0]          miss_pc_q;
   icache_pkg::line_t    line_q;
   logic                 fill_wr_q;
   logic                 stb_gap_q;

   assign last_beat = &beat_q;
   assign beat_ack  = (state_q == icache_pkg::IC_REFILL) && wb_rsp_i.ack;

   always_comb begin
      state_d     = state_q;
      fetch_rsp_o = '0;
      case (state_q)
         icache_pkg::IC_IDLE: begin
            if (!stall_i) state_d = icache_pkg::IC_LOOKUP;
         end
         icache_pkg::IC_LOOKUP: begin
            if (!stall_i) begin
               if (hit_i) begin
                  fetch_rsp_o.valid = 1'b1;
                  fetch_rsp_o.pc    = fetch_pc_i;
                  fetch_rsp_o.instr = hit_word_i;
                  state_d           = icache_pkg::IC_IDLE;
               end else begin
                  state_d = icache_pkg::IC_REFILL;
               end
            end
         end
         icache_pkg::IC_REFILL: begin
            if (beat_ack && last_beat) state_d = icache_pkg::IC_FILL;
         end
         icache_pkg::IC_FILL: begin
            if (!stall_i) begin
               // The pc may have moved on while the line was coming in.
               if (fetch_pc_i == miss_pc_q) begin
                  fetch_rsp_o.valid = 1'b1;
                  fetch_rsp_o.pc    = miss_pc_q;
                  fetch_rsp_o.instr = line_q[miss_pc_q[2 +: `OFS_BITS]];
               end
               state_d = icache_pkg::IC_IDLE;
            end
         end
         default: state_d = icache_pkg::IC_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state_q   <= icache_pkg::IC_IDLE;
         beat_q    <= '0;
         fill_wr_q <= 1'b0;
         stb_gap_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         fill_wr_q <= beat_ack && last_beat;  // One cycle, on entry to fill.
         stb_gap_q <= beat_ack;  // Stb low for one cycle after each ack.
         if (beat_ack) beat_q <= beat_q + 1'b1;  // Wraps to zero after the last beat.
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == icache_pkg::IC_LOOKUP && state_d == icache_pkg::IC_REFILL) begin
         miss_pc_q <= fetch_pc_i;
      end
      if (beat_ack) begin
         line_q[beat_q] <= wb_rsp_i.dat;
      end
   end

   // Cyc stays up across all beats of the refill.
   always_comb begin
      wb_req_o = '0;
      if (state_q == icache_pkg::IC_REFILL) begin
         wb_req_o.cyc = 1'b1;
         wb_req_o.stb = !stb_gap_q;
         wb_req_o.adr = {miss_pc_q[31:`OFS_BITS+2], beat_q, 2'b00};
      end
   end

   assign wr_en_o   = fill_wr_q;
   assign wr_pc_o   = miss_pc_q;
   assign wr_line_o = line_q;

endmodule

// ==== icache_array.sv ====
`include "fetch_macros.svh"

module icache_array (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [31:0]       lookup_pc_i,
   output logic              hit_o,
   output logic [31:0]       hit_word_o,
   input  logic              wr_en_i,
   input  logic [31:0]       wr_pc_i,
   input  icache_pkg::line_t wr_line_i
);

   localparam int TAG_LSB  = `IDX_BITS + `OFS_BITS + 2;
   localparam int TAG_BITS = 32 - TAG_LSB;

   logic [`ICACHE_LINES-1:0] valid_q;
   logic [TAG_BITS-1:0]      tag_q  [`ICACHE_LINES];
   icache_pkg::line_t        line_q [`ICACHE_LINES];

   logic [`IDX_BITS-1:0]     rd_idx;
   logic [`OFS_BITS-1:0]     rd_ofs;
   logic [`IDX_BITS-1:0]     wr_idx;

   assign rd_idx = lookup_pc_i[`OFS_BITS+2 +: `IDX_BITS];
   assign rd_ofs = lookup_pc_i[2 +: `OFS_BITS];
   assign wr_idx = wr_pc_i[`OFS_BITS+2 +: `IDX_BITS];

   // Combinational lookup.
   assign hit_o      = valid_q[rd_idx] && (tag_q[rd_idx] == lookup_pc_i[31:TAG_LSB]);
   assign hit_word_o = line_q[rd_idx][rd_ofs];

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         valid_q <= '0;
      end else if (wr_en_i) begin
         valid_q[wr_idx] <= 1'b1;
      end
   end

   // Whole line and tag are replaced together.
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         tag_q[wr_idx]  <= wr_pc_i[31:TAG_LSB];
         line_q[wr_idx] <= wr_line_i;
      end
   end

endmodule

// ==== icache_pkg.sv ====
`include "fetch_macros.svh"

package icache_pkg;

   typedef enum logic [1:0] {
      IC_IDLE,
      IC_LOOKUP,
      IC_REFILL,  // Line beats on the bus.
      IC_FILL     // Array write and delivery check.
   } ictrl_state_e;

   typedef struct packed {
      logic        valid;
      logic [31:0] pc;
      logic [31:0] instr;
   } fetch_rsp_t;

   // Word 0 sits in the low 32 bits.
   typedef logic [`LINE_WORDS-1:0][31:0] line_t;

endpackage

// ==== bus_pkg.sv ====
package bus_pkg;

   // Master to slave signals of a Wishbone classic cycle.
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [31:0] adr;  // Byte address.
      logic [31:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;
   } wb_rsp_t;

   typedef enum logic {
      DOP_LOAD,
      DOP_STORE
   } data_op_e;

   // Held stable by the requester until done.
   typedef struct packed {
      logic        valid;
      data_op_e    op;
      logic [31:0] addr;
      logic [31:0] wdata;
   } data_req_t;

endpackage

// ==== fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Direct-mapped instruction cache geometry.
`define ICACHE_LINES 16
`define IDX_BITS     4
`define LINE_WORDS   4
`define OFS_BITS     2

// Main memory depth in 32-bit words.
`define MEM_WORDS    1024

`endif
